// File: common/fpu_pkg.sv
package fpu_pkg;

	typedef enum logic [4:0] {
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_MUL,
		OP_MADD,
		OP_MSUB,
		OP_NMSUB,
		OP_NMADD
	} fp_op_t;

	typedef enum logic [2:0] {
		RM_RNE = 3'd0,
		RM_RTZ = 3'd1,
		RM_RDN = 3'd2,
		RM_RUP = 3'd3,
		RM_RMM = 3'd4
	} fp_rm_t;

	typedef struct packed {
		logic	nv;
		logic	of;
		logic	uf;
		logic	nx;
	} fp_flags_t;

	typedef struct packed {
		fp_op_t			op;
		fp_rm_t			rm;
		logic [31:0]	a;
		logic [31:0]	b;
		logic [31:0]	c;
	} fp_fused_req_t;

	typedef struct packed {
		fp_op_t			op;
		fp_rm_t			rm;
		logic [31:0]	a;
		logic [31:0]	b;
	} fp_core_req_t;

	typedef struct packed {
		logic [31:0]	result;
		fp_flags_t		flags;
	} fp_resp_t;

	// Mantissa is hidden bit, 23 fraction bits, then guard, round, sticky
	typedef struct packed {
		logic				sign;
		logic signed [9:0]	exp;
		logic [26:0]		mant;
		logic				is_zero;
		logic				is_inf;
		logic				is_nan;
		logic				nv;
	} fp_unrounded_t;

	localparam logic [31:0] FP_CANON_NAN = 32'h7fc00000;

endpackage

// File: fpu/fp_addsub.sv
`timescale 1ns/1ps

module fp_addsub (
	input	logic [31:0]				a,
	input	logic [31:0]				b,
	input	logic						subtract,
	output	fpu_pkg::fp_unrounded_t		sum
);
	logic			b_sign;
	logic			a_inf;
	logic			b_inf;
	logic			a_nan;
	logic			b_nan;
	logic			snan;
	logic			inf_minus_inf;
	logic			eff_sub;
	logic			swap;
	logic [7:0]		big_exp;
	logic [7:0]		small_exp;
	logic [26:0]	big_sig;
	logic [26:0]	small_sig;
	logic [7:0]		exp_diff;
	logic [4:0]		shift;
	logic [53:0]	small_ext;
	logic [26:0]	small_al;
	logic [27:0]	raw;
	logic [4:0]		lz;

	function automatic logic [4:0] lead_zeros(input logic [26:0] x);
		logic [4:0]	n;
		logic		found;
		n = 5'd0;
		found = 1'b0;
		for (int i = 26; i >= 0; i--) begin
			if (x[i])
				found = 1'b1;
			else if (!found)
				n = n + 5'd1;
		end
		return n;
	endfunction

	assign b_sign = b[31] ^ subtract;
	assign eff_sub = a[31] ^ b_sign;
	assign a_inf = a[30:23] == 8'hff && a[22:0] == 23'd0;
	assign b_inf = b[30:23] == 8'hff && b[22:0] == 23'd0;
	assign a_nan = a[30:23] == 8'hff && a[22:0] != 23'd0;
	assign b_nan = b[30:23] == 8'hff && b[22:0] != 23'd0;
	assign snan = (a_nan && !a[22]) || (b_nan && !b[22]);
	assign inf_minus_inf = a_inf && b_inf && eff_sub;

	//////////////////////////////////////////////////
	// Alignment of the smaller operand
	assign swap = b[30:0] > a[30:0];
	assign big_exp = swap ? b[30:23] : a[30:23];
	assign small_exp = swap ? a[30:23] : b[30:23];
	assign big_sig = {big_exp != 8'd0, swap ? b[22:0] : a[22:0], 3'b000};
	assign small_sig = {small_exp != 8'd0, swap ? a[22:0] : b[22:0], 3'b000};
	assign exp_diff = big_exp - small_exp;
	assign shift = (exp_diff > 8'd27) ? 5'd27 : exp_diff[4:0];
	assign small_ext = {small_sig, 27'd0} >> shift;
	assign small_al = {small_ext[53:28], |small_ext[27:0]};

	assign raw = eff_sub ? {1'b0, big_sig} - {1'b0, small_al}
		: {1'b0, big_sig} + {1'b0, small_al};
	assign lz = lead_zeros(raw[26:0]);

	always_comb begin
		sum.nv = snan || inf_minus_inf;
		sum.is_nan = a_nan || b_nan || inf_minus_inf;
		sum.is_inf = (a_inf || b_inf) && !sum.is_nan;
		sum.is_zero = raw == 28'd0 && !sum.is_nan && !sum.is_inf;
		if (a_inf)
			sum.sign = a[31];
		else if (b_inf)
			sum.sign = b_sign;
		else if (sum.is_zero)
			sum.sign = a[31] & b_sign;
		else
			sum.sign = swap ? b_sign : a[31];
		// Carry out shifts right, cancellation shifts left
		if (raw[27]) begin
			sum.exp = $signed({2'b00, big_exp}) + 10'sd1;
			sum.mant = {raw[27:2], raw[1] | raw[0]};
		end else begin
			sum.exp = $signed({2'b00, big_exp}) - $signed({5'd0, lz});
			sum.mant = raw[26:0] << lz;
		end
	end

endmodule

// File: fpu/fp_mul.sv
`timescale 1ns/1ps

module fp_mul (
	input	logic [31:0]				a,
	input	logic [31:0]				b,
	output	fpu_pkg::fp_unrounded_t		product
);
	logic				a_zero;
	logic				b_zero;
	logic				a_inf;
	logic				b_inf;
	logic				a_nan;
	logic				b_nan;
	logic				snan;
	logic				zero_times_inf;
	logic [47:0]		prod;
	logic signed [9:0]	exp_sum;

	assign a_zero = a[30:23] == 8'd0;
	assign b_zero = b[30:23] == 8'd0;
	assign a_inf = a[30:23] == 8'hff && a[22:0] == 23'd0;
	assign b_inf = b[30:23] == 8'hff && b[22:0] == 23'd0;
	assign a_nan = a[30:23] == 8'hff && a[22:0] != 23'd0;
	assign b_nan = b[30:23] == 8'hff && b[22:0] != 23'd0;
	assign snan = (a_nan && !a[22]) || (b_nan && !b[22]);
	assign zero_times_inf = (a_zero && b_inf) || (a_inf && b_zero);

	assign prod = {1'b1, a[22:0]} * {1'b1, b[22:0]};
	assign exp_sum = $signed({2'b00, a[30:23]}) + $signed({2'b00, b[30:23]}) - 10'sd127;

	always_comb begin
		product.sign = a[31] ^ b[31];
		product.nv = snan || zero_times_inf;
		product.is_nan = a_nan || b_nan || zero_times_inf;
		product.is_inf = (a_inf || b_inf) && !product.is_nan;
		product.is_zero = (a_zero || b_zero) && !product.is_nan && !product.is_inf;
		// Product of two significands lies in [1,4)
		if (prod[47]) begin
			product.exp = exp_sum + 10'sd1;
			product.mant = {prod[47:24], prod[23], prod[22], |prod[21:0]};
		end else begin
			product.exp = exp_sum;
			product.mant = {prod[46:23], prod[22], prod[21], |prod[20:0]};
		end
	end

endmodule

// File: fpu/fp_round_pack.sv
`timescale 1ns/1ps

module fp_round_pack #(
	parameter int ROUND_MODES_RMM = 1
) (
	input	fpu_pkg::fp_unrounded_t		value,
	input	fpu_pkg::fp_rm_t			rm,
	output	fpu_pkg::fp_resp_t			resp
);
	import fpu_pkg::*;

	fp_rm_t				rm_eff;
	logic				lsb;
	logic				guard;
	logic				sticky;
	logic				inexact;
	logic				round_up;
	logic				to_inf;
	logic [24:0]		rounded;
	logic signed [10:0]	exp_r;

	// Without the ties-away rounder RMM falls back to RNE
	assign rm_eff = (rm == RM_RMM && ROUND_MODES_RMM == 0) ? RM_RNE : rm;
	assign lsb = value.mant[3];
	assign guard = value.mant[2];
	assign sticky = value.mant[1] | value.mant[0];
	assign inexact = guard | sticky;

	always_comb begin
		case (rm_eff)
			RM_RTZ: round_up = 1'b0;
			RM_RDN: round_up = value.sign && inexact;
			RM_RUP: round_up = !value.sign && inexact;
			RM_RMM: round_up = guard;
			default: round_up = guard && (sticky || lsb);
		endcase
	end

	assign rounded = {1'b0, value.mant[26:3]} + {24'd0, round_up};
	assign exp_r = $signed({value.exp[9], value.exp}) + $signed({10'd0, rounded[24]});
	assign to_inf = !(rm_eff == RM_RTZ || (rm_eff == RM_RUP && value.sign)
		|| (rm_eff == RM_RDN && !value.sign));

	//////////////////////////////////////////////////
	// Special cases and packing
	always_comb begin
		resp.flags = '0;
		if (value.is_nan) begin
			resp.result = FP_CANON_NAN;
			resp.flags.nv = value.nv;
		end else if (value.is_inf) begin
			resp.result = {value.sign, 8'hff, 23'd0};
		end else if (value.is_zero) begin
			resp.result = {value.sign, 31'd0};
		end else if (exp_r >= 11'sd255) begin
			resp.result = to_inf ? {value.sign, 8'hff, 23'd0} : {value.sign, 8'hfe, 23'h7fffff};
			resp.flags.of = 1'b1;
			resp.flags.nx = 1'b1;
		end else if (exp_r < 11'sd1) begin
			// Tiny results flush to a signed zero
			resp.result = {value.sign, 31'd0};
			resp.flags.uf = 1'b1;
			resp.flags.nx = 1'b1;
		end else begin
			resp.result = {value.sign, exp_r[7:0], rounded[22:0]};
			resp.flags.nx = inexact;
		end
	end

endmodule

// File: fpu/fpu_core.sv
`timescale 1ns/1ps

module fpu_core #(
	parameter int ROUND_MODES_RMM = 1
) (
	input	logic						clk,
	input	logic						reset,
	input	logic						flush,
	input	logic						valid_in,
	output	logic						ready_out,
	input	fpu_pkg::fp_core_req_t		req,
	output	logic						valid_out,
	output	fpu_pkg::fp_resp_t			resp
);
	import fpu_pkg::*;

	logic			s1_valid;
	fp_core_req_t	s1_req;
	logic			s2_valid;
	logic			do_sub;
	fp_unrounded_t	sum;
	fp_unrounded_t	product;
	fp_unrounded_t	selected;
	fp_resp_t		packed_resp;

	// Subnormals read as zero of the same sign
	function automatic logic [31:0] daz(input logic [31:0] x);
		return (x[30:23] == 8'd0) ? {x[31], 31'd0} : x;
	endfunction

	assign ready_out = !s1_valid && !s2_valid;
	assign valid_out = s2_valid;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else if (flush) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= valid_in && ready_out;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_in && ready_out)
			s1_req <= '{op: req.op, rm: req.rm, a: daz(req.a), b: daz(req.b)};
		if (s1_valid)
			resp <= packed_resp;
	end

	//////////////////////////////////////////////////
	// Datapaths
	assign do_sub = s1_req.op == OP_SUB;

	fp_addsub addsub0 (
		.a(s1_req.a),
		.b(s1_req.b),
		.subtract(do_sub),
		.sum(sum)
	);

	fp_mul mul0 (
		.a(s1_req.a),
		.b(s1_req.b),
		.product(product)
	);

	always_comb begin
		selected = (s1_req.op == OP_MUL) ? product : sum;
		// Zero from opposite signs is -0 only when rounding down
		if (s1_req.op != OP_MUL && selected.is_zero && (s1_req.a[31] ^ s1_req.b[31] ^ do_sub))
			selected.sign = s1_req.rm == RM_RDN;
	end

	fp_round_pack #(
		.ROUND_MODES_RMM(ROUND_MODES_RMM)
	) round0 (
		.value(selected),
		.rm(s1_req.rm),
		.resp(packed_resp)
	);

	assert property (@(posedge clk) disable iff (reset)
		valid_in && ready_out |-> req.op inside {OP_ADD, OP_SUB, OP_MUL});

endmodule

// File: fpu/fpu_sequencer.sv
`timescale 1ns/1ps

module fpu_sequencer (
	input	logic						clk,
	input	logic						reset,
	input	logic						flush,
	input	logic						valid_in,
	output	logic						ready_out,
	input	fpu_pkg::fp_fused_req_t		req,
	output	logic						valid_out,
	input	logic						ready_in,
	output	fpu_pkg::fp_resp_t			resp,
	output	logic						core_valid,
	output	fpu_pkg::fp_core_req_t		core_req,
	input	logic						core_ready,
	input	logic						core_valid_out,
	input	fpu_pkg::fp_resp_t			core_resp
);
	import fpu_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		PASS1,
		PASS2,
		HOLD
	} state_t;

	state_t			state;
	fp_op_t			op_q;
	logic [31:0]	c_q;
	fp_flags_t		flags_q;
	fp_resp_t		resp_q;
	fp_resp_t		merged;
	logic			accept;
	logic			fused;
	logic			negate;

	assign accept = valid_in && ready_out;
	assign fused = req.op inside {OP_MADD, OP_MSUB, OP_NMSUB, OP_NMADD};
	assign negate = op_q == OP_NMSUB || op_q == OP_NMADD;

	// Final flags carry whatever the product pass raised
	always_comb begin
		merged.result = core_resp.result;
		merged.flags = core_resp.flags | flags_q;
	end

	assign ready_out = state == IDLE;
	assign valid_out = state == HOLD || (state == PASS2 && core_valid_out);
	assign resp = (state == HOLD) ? resp_q : merged;

	//////////////////////////////////////////////////
	// Control
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			core_valid <= 1'b0;
		end else if (flush) begin
			state <= IDLE;
			core_valid <= 1'b0;
		end else begin
			if (core_valid && core_ready)
				core_valid <= 1'b0;
			case (state)
				IDLE: if (accept) begin
					state <= fused ? PASS1 : PASS2;
					core_valid <= 1'b1;
				end
				PASS1: if (core_valid_out) begin
					state <= PASS2;
					core_valid <= 1'b1;
				end
				PASS2: if (core_valid_out)
					state <= ready_in ? IDLE : HOLD;
				HOLD: if (ready_in)
					state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Request and result payload
	always_ff @(posedge clk) begin
		case (state)
			IDLE: if (accept) begin
				core_req <= '{op: fused ? OP_MUL : req.op, rm: req.rm, a: req.a, b: req.b};
				op_q <= req.op;
				c_q <= req.c;
				flags_q <= '0;
			end
			// Second pass adds or subtracts c from the rounded product
			PASS1: if (core_valid_out) begin
				core_req.op <= (op_q == OP_MADD || op_q == OP_NMSUB) ? OP_ADD : OP_SUB;
				core_req.a <= {core_resp.result[31] ^ negate, core_resp.result[30:0]};
				core_req.b <= c_q;
				flags_q <= core_resp.flags;
			end
			PASS2: if (core_valid_out)
				resp_q <= merged;
			default: ;
		endcase
	end

	assert property (@(posedge clk) disable iff (reset || flush)
		valid_out && !ready_in |=> valid_out && $stable(resp));

endmodule

// File: hw/fpu_top.sv
`timescale 1ns/1ps

module fpu_top #(
	parameter int ROUND_MODES_RMM = 1
) (
	input	logic						clk,
	input	logic						reset,
	input	logic						flush,
	input	logic						valid_in,
	output	logic						ready_out,
	input	fpu_pkg::fp_fused_req_t		req,
	output	logic						valid_out,
	input	logic						ready_in,
	output	fpu_pkg::fp_resp_t			resp
);
	import fpu_pkg::*;

	logic			core_valid;
	fp_core_req_t	core_req;
	logic			core_ready;
	logic			core_valid_out;
	fp_resp_t		core_resp;

	fpu_sequencer seq0 (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.valid_in(valid_in),
		.ready_out(ready_out),
		.req(req),
		.valid_out(valid_out),
		.ready_in(ready_in),
		.resp(resp),
		.core_valid(core_valid),
		.core_req(core_req),
		.core_ready(core_ready),
		.core_valid_out(core_valid_out),
		.core_resp(core_resp)
	);

	fpu_core #(
		.ROUND_MODES_RMM(ROUND_MODES_RMM)
	) core0 (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.valid_in(core_valid),
		.ready_out(core_ready),
		.req(core_req),
		.valid_out(core_valid_out),
		.resp(core_resp)
	);

endmodule

// File: test/fpu_tb.sv
`timescale 1ns/1ps

module fpu_tb;
	import fpu_pkg::*;

	localparam int TIMEOUT_CYCLES = 4000;

	// Flag patterns in nv, of, uf, nx order
	localparam logic [3:0] FL_NONE = 4'b0000;
	localparam logic [3:0] FL_NX = 4'b0001;
	localparam logic [3:0] FL_UF_NX = 4'b0011;
	localparam logic [3:0] FL_OF_NX = 4'b0101;
	localparam logic [3:0] FL_NV = 4'b1000;

	localparam logic [31:0] F_ONE = 32'h3f800000;
	localparam logic [31:0] F_TWO = 32'h40000000;
	localparam logic [31:0] F_THREE = 32'h40400000;
	localparam logic [31:0] F_INF = 32'h7f800000;
	localparam logic [31:0] F_MAX = 32'h7f7fffff;
	localparam logic [31:0] F_ONE_ULP = 32'h3f800001;

	logic			clk;
	logic			reset;
	logic			flush;
	logic			valid_in;
	logic			ready_out;
	fp_fused_req_t	req;
	logic			valid_out;
	logic			ready_in;
	fp_resp_t		resp;

	int				cycles;
	int				accepted;
	int				returned;
	int				dropped;
	logic [31:0]	lcg_state;

	fpu_top #(
		.ROUND_MODES_RMM(1)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.valid_in(valid_in),
		.ready_out(ready_out),
		.req(req),
		.valid_out(valid_out),
		.ready_in(ready_in),
		.resp(resp)
	);

	always #4 clk = ~clk;

	//////////////////////////////////////////////////
	// Timeout and transfer counting
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (!reset && !flush && valid_in && ready_out)
			accepted <= accepted + 1;
		if (!reset && !flush && valid_out && ready_in)
			returned <= returned + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	//////////////////////////////////////////////////
	// Compare tasks
	task automatic check_result(input fp_resp_t got, input fp_resp_t expected,
			input string what);
		if (got.result !== expected.result) begin
			$display("ERROR at %0t ns: %s result got %h, expected %h", $time, what,
				got.result, expected.result);
			$display("TEST FAILED");
			$fatal(1, "Result mismatch");
		end
	endtask

	task automatic check_flags(input fp_flags_t got, input fp_flags_t expected,
			input string what);
		if (got !== expected) begin
			$display("ERROR at %0t ns: %s flags got %b, expected %b", $time, what,
				got, expected);
			$display("TEST FAILED");
			$fatal(1, "Flag mismatch");
		end
	endtask

	task automatic check_count(input int got, input int expected, input string what);
		if (got != expected) begin
			$display("ERROR at %0t ns: %s got %0d, expected %0d", $time, what, got, expected);
			$display("TEST FAILED");
			$fatal(1, "Count mismatch");
		end
	endtask

	//////////////////////////////////////////////////
	// Driver, entered and left 1 ns after a rising edge
	task automatic send(input fp_op_t op, input fp_rm_t rm, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] c);
		req.op = op;
		req.rm = rm;
		req.a = a;
		req.b = b;
		req.c = c;
		valid_in = 1'b1;
		while (!ready_out) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		valid_in = 1'b0;
	endtask

	task automatic run_op(input fp_op_t op, input fp_rm_t rm, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] c, input logic [31:0] exp_result,
			input logic [3:0] exp_flags, input string what);
		fp_resp_t	got;
		fp_resp_t	expected;
		int			edges;
		expected.result = exp_result;
		expected.flags = exp_flags;
		send(op, rm, a, b, c);
		// Accept edge counts as the first
		edges = 1;
		while (!valid_out) begin
			@(posedge clk);
			#1;
			edges++;
		end
		got = resp;
		@(posedge clk);
		#1;
		check_result(got, expected, what);
		check_flags(got.flags, expected.flags, what);
		check_count(edges, (op >= OP_MADD) ? 6 : 3, {what, " latency in edges"});
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	task automatic test_exact_ops();
		run_op(OP_ADD, RM_RNE, 32'h3fc00000, 32'h40100000, 0, 32'h40700000, FL_NONE,
			"1.5+2.25");
		run_op(OP_SUB, RM_RNE, F_THREE, 32'h40a00000, 0, 32'hc0000000, FL_NONE, "3.0-5.0");
		run_op(OP_MUL, RM_RNE, 32'hc0200000, 32'h40800000, 0, 32'hc1200000, FL_NONE,
			"-2.5*4.0");
		run_op(OP_SUB, RM_RNE, 32'h3fc00000, 32'h3fc00000, 0, 32'h00000000, FL_NONE,
			"zero sum RNE");
		run_op(OP_SUB, RM_RDN, 32'h3fc00000, 32'h3fc00000, 0, 32'h80000000, FL_NONE,
			"zero sum RDN");
	endtask

	task automatic test_rounding_modes();
		// Product is 1+2^-22+2^-46, below the halfway point
		run_op(OP_MUL, RM_RNE, F_ONE_ULP, F_ONE_ULP, 0, 32'h3f800002, FL_NX, "mul RNE");
		run_op(OP_MUL, RM_RTZ, F_ONE_ULP, F_ONE_ULP, 0, 32'h3f800002, FL_NX, "mul RTZ");
		run_op(OP_MUL, RM_RDN, F_ONE_ULP, F_ONE_ULP, 0, 32'h3f800002, FL_NX, "mul RDN");
		run_op(OP_MUL, RM_RUP, F_ONE_ULP, F_ONE_ULP, 0, 32'h3f800003, FL_NX, "mul RUP");
		run_op(OP_MUL, RM_RMM, F_ONE_ULP, F_ONE_ULP, 0, 32'h3f800002, FL_NX, "mul RMM");
		// (1+2^-12)^2 lands exactly halfway with an even LSB
		run_op(OP_MUL, RM_RNE, 32'h3f800800, 32'h3f800800, 0, 32'h3f801000, FL_NX,
			"tie RNE");
		run_op(OP_MUL, RM_RMM, 32'h3f800800, 32'h3f800800, 0, 32'h3f801001, FL_NX,
			"tie RMM");
	endtask

	task automatic test_multiply_add();
		run_op(OP_MADD, RM_RNE, F_TWO, F_THREE, F_ONE, 32'h40e00000, FL_NONE, "MADD");
		run_op(OP_MSUB, RM_RNE, F_TWO, F_THREE, F_ONE, 32'h40a00000, FL_NONE, "MSUB");
		run_op(OP_NMSUB, RM_RNE, F_TWO, F_THREE, F_ONE, 32'hc0a00000, FL_NONE, "NMSUB");
		run_op(OP_NMADD, RM_RNE, F_TWO, F_THREE, F_ONE, 32'hc0e00000, FL_NONE, "NMADD");
		// Inexact product, exact sum 2+2^-22
		run_op(OP_MADD, RM_RNE, F_ONE_ULP, F_ONE_ULP, F_ONE, 32'h40000001, FL_NX,
			"MADD inexact product");
	endtask

	task automatic test_special_values();
		run_op(OP_SUB, RM_RNE, F_INF, F_INF, 0, FP_CANON_NAN, FL_NV, "inf-inf");
		run_op(OP_MUL, RM_RNE, 32'h00000000, F_INF, 0, FP_CANON_NAN, FL_NV, "0*inf");
		run_op(OP_ADD, RM_RNE, 32'h7fc00001, F_ONE, 0, FP_CANON_NAN, FL_NONE, "qNaN+1");
		run_op(OP_ADD, RM_RNE, 32'h7f800001, F_ONE, 0, FP_CANON_NAN, FL_NV, "sNaN+1");
		run_op(OP_MUL, RM_RNE, F_MAX, F_TWO, 0, F_INF, FL_OF_NX, "max*2 RNE");
		run_op(OP_MUL, RM_RTZ, F_MAX, F_TWO, 0, F_MAX, FL_OF_NX, "max*2 RTZ");
		run_op(OP_MUL, RM_RNE, 32'h0d800000, 32'h0d800000, 0, 32'h00000000, FL_UF_NX,
			"2^-100*2^-100");
	endtask

	task automatic test_back_pressure();
		fp_resp_t	held;
		fp_resp_t	expected;
		int			stall;
		for (int i = 0; i < 8; i++) begin
			ready_in = 1'b0;
			expected.flags = FL_NONE;
			case (i % 4)
				0: begin
					send(OP_ADD, RM_RNE, 32'h3fc00000, 32'h40100000, 0);
					expected.result = 32'h40700000;
				end
				1: begin
					send(OP_SUB, RM_RNE, F_THREE, 32'h40a00000, 0);
					expected.result = 32'hc0000000;
				end
				2: begin
					send(OP_MUL, RM_RNE, 32'hc0200000, 32'h40800000, 0);
					expected.result = 32'hc1200000;
				end
				default: begin
					send(OP_MADD, RM_RNE, F_TWO, F_THREE, F_ONE);
					expected.result = 32'h40e00000;
				end
			endcase
			while (!valid_out) begin
				@(posedge clk);
				#1;
			end
			held = resp;
			stall = (next_random() >> 16) % 16;
			repeat (stall) begin
				@(posedge clk);
				#1;
				check_count(valid_out, 1, "valid_out under back-pressure");
				check_count(ready_out, 0, "ready_out under back-pressure");
				check_result(resp, held, "held resp");
				check_flags(resp.flags, held.flags, "held resp");
			end
			ready_in = 1'b1;
			@(posedge clk);
			#1;
			check_result(held, expected, "back-pressure result");
			check_flags(held.flags, expected.flags, "back-pressure result");
			check_count(valid_out, 0, "valid_out after transfer");
		end
	endtask

	task automatic test_flush();
		send(OP_MADD, RM_RNE, F_TWO, F_THREE, F_ONE);
		// Four more edges put the add pass in the core input stage
		repeat (4) begin
			@(posedge clk);
			#1;
			check_count(valid_out, 0, "valid_out before flush");
		end
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
		dropped++;
		repeat (8) begin
			@(posedge clk);
			#1;
			check_count(valid_out, 0, "valid_out after flush");
		end
		check_count(ready_out, 1, "ready_out after flush");
		run_op(OP_ADD, RM_RNE, 32'h3fc00000, 32'h40100000, 0, 32'h40700000, FL_NONE,
			"add after flush");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		flush = 1'b0;
		valid_in = 1'b0;
		ready_in = 1'b1;
		req = '0;
		cycles = 0;
		accepted = 0;
		returned = 0;
		dropped = 0;
		lcg_state = 32'h8916;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;

		test_exact_ops();
		test_rounding_modes();
		test_multiply_add();
		test_special_values();
		test_back_pressure();
		test_flush();

		@(posedge clk);
		#1;
		if (returned != accepted - dropped) begin
			$display("Result count is wrong: %0d accepted, %0d dropped, %0d returned",
				accepted, dropped, returned);
			$display("TEST FAILED");
			$fatal(1, "Result count mismatch");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

// File: sim.f
common/fpu_pkg.sv
fpu/fp_addsub.sv
fpu/fp_mul.sv
fpu/fp_round_pack.sv
fpu/fpu_core.sv
fpu/fpu_sequencer.sv
hw/fpu_top.sv
test/fpu_tb.sv
